/* source/hysteresis_settings.svh */
`ifndef HYSTERESIS_SETTINGS_SVH
`define HYSTERESIS_SETTINGS_SVH

// Frame geometry in pixels
`define IMAGE_WIDTH 8
`define IMAGE_HEIGHT 5

// Gradient limits, both compared strictly
`define HIGH_THRESHOLD 48
`define LOW_THRESHOLD 12

// Input buffering, kept a power of two so the pointers wrap naturally
`define INPUT_FIFO_DEPTH 16

`endif

/* source/hysteresis_pkg.sv */
`include "hysteresis_settings.svh"

package hysteresis_pkg;

    // One gradient magnitude sample
    typedef logic [7:0] pixel_t;

    // Linear position inside the edge map
    typedef logic [$clog2(`IMAGE_WIDTH * `IMAGE_HEIGHT)-1:0] addr_t;

    // 3x3 neighbourhood, top-left first, centre at index 4
    typedef pixel_t [0:8] window_t;

    typedef enum logic [1:0] {
        IDLE,
        PROLOGUE,
        COMPUTE,
        WRITE
    } ctrl_state_t;

endpackage

/* source/pixel_fifo.sv */
`timescale 1ns/1ps

`include "hysteresis_settings.svh"

module pixel_fifo #(
    parameter int DEPTH = `INPUT_FIFO_DEPTH
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wr_en,
    input  hysteresis_pkg::pixel_t wr_data,
    output logic                  full,
    input  logic                  rd_en,
    output hysteresis_pkg::pixel_t rd_data,
    output logic                  empty
);
    import hysteresis_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    pixel_t storage [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_write;
    logic do_read;

    assign do_write = wr_en && !full;
    assign do_read = rd_en && !empty;

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Head word is visible without a read strobe
    assign rd_data = storage[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            storage[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The pixel source has to respect full
    assert property (@(posedge clock) disable iff (reset) !(wr_en && full));

    // The controller only pops a word that is present
    assert property (@(posedge clock) disable iff (reset) !(rd_en && empty));

endmodule

/* source/hysteresis_control.sv */
`timescale 1ns/1ps

module hysteresis_control (
    input  logic clock,
    input  logic reset,
    input  logic fifo_empty,
    input  logic input_exhausted,
    input  logic prologue_done,
    input  logic frame_last,
    input  logic highlight_full,
    output logic fifo_pop,
    output logic window_shift,
    output logic count_prologue,
    output logic classify_load,
    output logic map_wr_en,
    output logic highlight_wr_en,
    output logic advance,
    output logic frame_done
);
    import hysteresis_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic step;

    // A shift can happen when a pixel is waiting or padding has started
    assign step = input_exhausted || !fifo_empty;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= PROLOGUE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        fifo_pop = 1'b0;
        window_shift = 1'b0;
        count_prologue = 1'b0;
        classify_load = 1'b0;
        map_wr_en = 1'b0;
        highlight_wr_en = 1'b0;
        advance = 1'b0;
        frame_done = 1'b0;

        case (state)
            IDLE: begin
                next_state = PROLOGUE;
            end

            PROLOGUE: begin
                // Fill the window until the first centre pixel sits in place
                if (prologue_done) begin
                    next_state = COMPUTE;
                end else if (step) begin
                    fifo_pop = !input_exhausted;
                    window_shift = 1'b1;
                    count_prologue = 1'b1;
                end
            end

            COMPUTE: begin
                if (step) begin
                    fifo_pop = !input_exhausted;
                    window_shift = 1'b1;
                    classify_load = 1'b1;
                    next_state = WRITE;
                end
            end

            WRITE: begin
                // RAM write repeats each cycle the highlight FIFO holds us off
                map_wr_en = 1'b1;
                if (!highlight_full) begin
                    highlight_wr_en = 1'b1;
                    advance = 1'b1;
                    if (frame_last) begin
                        frame_done = 1'b1;
                        next_state = IDLE;
                    end else begin
                        next_state = COMPUTE;
                    end
                end
            end
        endcase
    end

    // The window is primed from real input before any padding starts
    assert property (@(posedge clock) disable iff (reset)
        (state == PROLOGUE) |-> !input_exhausted);

endmodule

/* source/raster_counter.sv */
`timescale 1ns/1ps

`include "hysteresis_settings.svh"

module raster_counter (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               count_prologue,
    input  logic                               advance,
    input  logic                               frame_done,
    output logic [$clog2(`IMAGE_HEIGHT)-1:0]   row,
    output logic [$clog2(`IMAGE_WIDTH)-1:0]    col,
    output logic                               prologue_done,
    output logic                               input_exhausted,
    output logic                               on_border,
    output logic                               frame_last
);
    localparam int ROW_W = $clog2(`IMAGE_HEIGHT);
    localparam int COL_W = $clog2(`IMAGE_WIDTH);
    localparam int PRO_W = $clog2(`IMAGE_WIDTH + 3);
    localparam int POS_W = $clog2(`IMAGE_WIDTH * `IMAGE_HEIGHT);
    // Last centre position whose step still pulls a real input pixel
    localparam int STOP_POINT = `IMAGE_WIDTH * `IMAGE_HEIGHT - `IMAGE_WIDTH - 3;

    logic [PRO_W-1:0] prologue_count;
    logic [POS_W-1:0] position;

    assign position = POS_W'(row) * POS_W'(`IMAGE_WIDTH) + POS_W'(col);

    assign prologue_done = (prologue_count == PRO_W'(`IMAGE_WIDTH + 2));
    assign input_exhausted = (position > POS_W'(STOP_POINT));
    assign on_border = (row == '0) || (row == ROW_W'(`IMAGE_HEIGHT - 1))
                    || (col == '0) || (col == COL_W'(`IMAGE_WIDTH - 1));
    assign frame_last = (row == ROW_W'(`IMAGE_HEIGHT - 1)) && (col == COL_W'(`IMAGE_WIDTH - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            prologue_count <= '0;
            row <= '0;
            col <= '0;
        end else if (frame_done) begin
            // Start over for the next frame
            prologue_count <= '0;
            row <= '0;
            col <= '0;
        end else begin
            if (count_prologue) begin
                prologue_count <= prologue_count + 1'b1;
            end
            if (advance) begin
                if (col == COL_W'(`IMAGE_WIDTH - 1)) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

endmodule

/* source/window_buffer.sv */
`timescale 1ns/1ps

`include "hysteresis_settings.svh"

module window_buffer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    shift,
    input  logic                    zero_fill,
    input  hysteresis_pkg::pixel_t  shift_data,
    output hysteresis_pkg::window_t window
);
    import hysteresis_pkg::*;

    localparam int W = `IMAGE_WIDTH;
    localparam int SHIFT_LEN = 2 * W + 3;

    // Entry 0 holds the oldest pixel, new data enters at the far end
    pixel_t [0:SHIFT_LEN-1] shift_reg;
    pixel_t shift_in;

    // Padding after the last input pixel of the frame
    assign shift_in = zero_fill ? '0 : shift_data;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            shift_reg <= '0;
        end else if (shift) begin
            shift_reg <= {shift_reg[1:SHIFT_LEN-1], shift_in};
        end
    end

    // Top row
    assign window[0] = shift_reg[0];
    assign window[1] = shift_reg[1];
    assign window[2] = shift_reg[2];

    // Middle row, centre at W+1
    assign window[3] = shift_reg[W];
    assign window[4] = shift_reg[W + 1];
    assign window[5] = shift_reg[W + 2];

    // Bottom row
    assign window[6] = shift_reg[2 * W];
    assign window[7] = shift_reg[2 * W + 1];
    assign window[8] = shift_reg[2 * W + 2];

endmodule

/* source/edge_classifier.sv */
`timescale 1ns/1ps

`include "hysteresis_settings.svh"

module edge_classifier (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    load,
    input  logic                    on_border,
    input  hysteresis_pkg::window_t window,
    output hysteresis_pkg::pixel_t  edge_value
);
    import hysteresis_pkg::*;

    pixel_t centre;
    logic strong_neighbour;
    logic keep;

    assign centre = window[4];

    always_comb begin
        strong_neighbour = 1'b0;
        for (int i = 0; i < 9; i++) begin
            if (i != 4 && window[i] > pixel_t'(`HIGH_THRESHOLD)) begin
                strong_neighbour = 1'b1;
            end
        end
    end

    // Strong pixels survive on their own, weak ones need a strong neighbour
    assign keep = (centre > pixel_t'(`HIGH_THRESHOLD))
               || ((centre > pixel_t'(`LOW_THRESHOLD)) && strong_neighbour);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            edge_value <= '0;
        end else if (load) begin
            if (keep && !on_border) begin
                edge_value <= centre;
            end else begin
                edge_value <= '0;
            end
        end
    end

endmodule

/* source/edge_map_ram.sv */
`timescale 1ns/1ps

`include "hysteresis_settings.svh"

module edge_map_ram (
    input  logic                             clock,
    input  logic                             wr_en,
    input  logic [$clog2(`IMAGE_HEIGHT)-1:0] row,
    input  logic [$clog2(`IMAGE_WIDTH)-1:0]  col,
    input  hysteresis_pkg::pixel_t           wr_data,
    input  hysteresis_pkg::addr_t            rd_addr,
    output hysteresis_pkg::pixel_t           rd_data
);
    import hysteresis_pkg::*;

    localparam int FRAME_SIZE = `IMAGE_WIDTH * `IMAGE_HEIGHT;

    pixel_t mem [FRAME_SIZE];
    addr_t wr_addr;

    assign wr_addr = addr_t'(row) * addr_t'(`IMAGE_WIDTH) + addr_t'(col);

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

    // Row and column counters must never point past the frame
    assert property (@(posedge clock) wr_en |-> wr_addr < addr_t'(FRAME_SIZE));

endmodule

/* source/hysteresis_top.sv */
`timescale 1ns/1ps

`include "hysteresis_settings.svh"

module hysteresis_top (
    input  logic                   clock,
    input  logic                   reset,
    input  hysteresis_pkg::pixel_t pixel_in,
    input  logic                   pixel_wr_en,
    output logic                   pixel_full,
    output hysteresis_pkg::pixel_t highlight_data,
    output logic                   highlight_wr_en,
    input  logic                   highlight_full,
    output logic                   frame_done,
    input  hysteresis_pkg::addr_t  map_rd_addr,
    output hysteresis_pkg::pixel_t map_rd_data
);
    import hysteresis_pkg::*;

    pixel_t fifo_data;
    logic fifo_empty;
    logic fifo_pop;
    logic window_shift;
    logic count_prologue;
    logic classify_load;
    logic map_wr_en;
    logic advance;
    logic prologue_done;
    logic input_exhausted;
    logic on_border;
    logic frame_last;
    logic [$clog2(`IMAGE_HEIGHT)-1:0] row;
    logic [$clog2(`IMAGE_WIDTH)-1:0] col;
    window_t window;
    pixel_t edge_value;

    pixel_fifo #(
        .DEPTH(`INPUT_FIFO_DEPTH)
    ) u_input_fifo (
        .clock(clock),
        .reset(reset),
        .wr_en(pixel_wr_en),
        .wr_data(pixel_in),
        .full(pixel_full),
        .rd_en(fifo_pop),
        .rd_data(fifo_data),
        .empty(fifo_empty)
    );

    hysteresis_control u_control (
        .clock(clock),
        .reset(reset),
        .fifo_empty(fifo_empty),
        .input_exhausted(input_exhausted),
        .prologue_done(prologue_done),
        .frame_last(frame_last),
        .highlight_full(highlight_full),
        .fifo_pop(fifo_pop),
        .window_shift(window_shift),
        .count_prologue(count_prologue),
        .classify_load(classify_load),
        .map_wr_en(map_wr_en),
        .highlight_wr_en(highlight_wr_en),
        .advance(advance),
        .frame_done(frame_done)
    );

    raster_counter u_raster (
        .clock(clock),
        .reset(reset),
        .count_prologue(count_prologue),
        .advance(advance),
        .frame_done(frame_done),
        .row(row),
        .col(col),
        .prologue_done(prologue_done),
        .input_exhausted(input_exhausted),
        .on_border(on_border),
        .frame_last(frame_last)
    );

    // Zero padding once the whole frame has been shifted in
    window_buffer u_window (
        .clock(clock),
        .reset(reset),
        .shift(window_shift),
        .zero_fill(input_exhausted),
        .shift_data(fifo_data),
        .window(window)
    );

    edge_classifier u_classifier (
        .clock(clock),
        .reset(reset),
        .load(classify_load),
        .on_border(on_border),
        .window(window),
        .edge_value(edge_value)
    );

    edge_map_ram u_edge_map (
        .clock(clock),
        .wr_en(map_wr_en),
        .row(row),
        .col(col),
        .wr_data(edge_value),
        .rd_addr(map_rd_addr),
        .rd_data(map_rd_data)
    );

    assign highlight_data = edge_value;

endmodule

/* testbench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // Release on a falling edge, away from the flops' active edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

/* testbench/hysteresis_tb.sv */
`timescale 1ns/1ps

`include "hysteresis_settings.svh"

module hysteresis_tb;
    import hysteresis_pkg::*;

    localparam int FRAME_SIZE = `IMAGE_WIDTH * `IMAGE_HEIGHT;
    localparam int FRAME_COUNT = 2;
    localparam int FRAME_TIMEOUT = 2000;
    localparam int RESET_TIMEOUT = 100;
    localparam int SETTLE_CYCLES = 4;

    logic clock;
    logic reset;
    pixel_t pixel_in;
    logic pixel_wr_en;
    logic pixel_full;
    pixel_t highlight_data;
    logic highlight_wr_en;
    logic highlight_full;
    logic frame_done;
    addr_t map_rd_addr;
    pixel_t map_rd_data;

    // Even entries hold input pixels, odd entries the expected result
    pixel_t testdata [2 * FRAME_SIZE];
    int error_count;
    int check_count;
    logic timed_out;

    clock_gen #(
        .PERIOD_NS(10),
        .RESET_CYCLES(16)
    ) u_clock_gen (
        .clock(clock),
        .reset(reset)
    );

    hysteresis_top u_dut (
        .clock(clock),
        .reset(reset),
        .pixel_in(pixel_in),
        .pixel_wr_en(pixel_wr_en),
        .pixel_full(pixel_full),
        .highlight_data(highlight_data),
        .highlight_wr_en(highlight_wr_en),
        .highlight_full(highlight_full),
        .frame_done(frame_done),
        .map_rd_addr(map_rd_addr),
        .map_rd_data(map_rd_data)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                     $time, name, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        timed_out = 1'b1;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(posedge clock);
        while (reset && cycles < RESET_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (reset) begin
            report_timeout("reset release");
        end
    endtask

    task automatic run_frame(input int frame_index);
        int pushed;
        int received;
        int done_pulses;
        int cycles;
        pushed = 0;
        received = 0;
        done_pulses = 0;
        cycles = 0;
        while (received < FRAME_SIZE && cycles < FRAME_TIMEOUT) begin
            @(negedge clock);
            cycles++;
            // Random gaps in the pixel stream
            if (pushed < FRAME_SIZE && !pixel_full && ($urandom % 4) != 0) begin
                pixel_in = testdata[2 * pushed];
                pixel_wr_en = 1'b1;
                pushed++;
            end else begin
                pixel_in = '0;
                pixel_wr_en = 1'b0;
            end
            highlight_full = ($urandom % 3) == 0;
            // Outputs settle well before the next rising edge
            #2;
            if (highlight_full) begin
                check_value("highlight_wr_en", highlight_wr_en, 0);
            end else if (highlight_wr_en) begin
                check_value($sformatf("highlight_data[%0d] frame %0d", received, frame_index),
                            highlight_data, testdata[2 * received + 1]);
                received++;
            end
            if (frame_done) begin
                done_pulses++;
                check_value("highlight_wr_en with frame_done", highlight_wr_en, 1);
                check_value("pushes at frame_done", received, FRAME_SIZE);
            end
        end
        if (received < FRAME_SIZE) begin
            report_timeout($sformatf("highlight values of frame %0d", frame_index));
        end else begin
            // Block sits idle now, so no further push or pulse may show up
            repeat (SETTLE_CYCLES) begin
                @(negedge clock);
                pixel_wr_en = 1'b0;
                pixel_in = '0;
                highlight_full = 1'b0;
                #2;
                check_value("highlight_wr_en after frame", highlight_wr_en, 0);
                if (frame_done) begin
                    done_pulses++;
                end
            end
            check_value("frame_done pulses", done_pulses, 1);
        end
    endtask

    // Read data comes back one edge after the address
    task automatic check_edge_map(input int frame_index);
        for (int addr = 0; addr < FRAME_SIZE; addr++) begin
            @(negedge clock);
            map_rd_addr = addr_t'(addr);
            @(negedge clock);
            check_value($sformatf("map_rd_data[%0d] frame %0d", addr, frame_index),
                        map_rd_data, testdata[2 * addr + 1]);
        end
    endtask

    initial begin
        pixel_in = '0;
        pixel_wr_en = 1'b0;
        highlight_full = 1'b0;
        map_rd_addr = '0;
        error_count = 0;
        check_count = 0;
        timed_out = 1'b0;
        void'($urandom(32'h53ac_923a));

        for (int i = 0; i < 2 * FRAME_SIZE; i++) begin
            testdata[i] = pixel_t'(8'hc3 ^ i);
        end
        $readmemh("testbench/hysteresis_testdata.hex", testdata);
        if (testdata[2 * FRAME_SIZE - 1] === pixel_t'(8'hc3 ^ (2 * FRAME_SIZE - 1))) begin
            error_count++;
            $display("Test data file is missing or too short");
        end

        if (error_count == 0) begin
            wait_reset_release();
            if (!timed_out) begin
                @(negedge clock);
                #2;
                check_value("pixel_full", pixel_full, 0);
                check_value("highlight_wr_en", highlight_wr_en, 0);
                check_value("frame_done", frame_done, 0);
            end
            for (int f = 0; f < FRAME_COUNT && !timed_out; f++) begin
                run_frame(f);
                if (!timed_out) begin
                    check_edge_map(f);
                end
            end
        end

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* testbench/hysteresis_testdata.hex */
// Column 1 holds the input gradient pixel in raster order
// Column 2 holds the expected hysteresis result for that pixel
// row 0
05 00
3c 00
14 00
00 00
00 00
0e 00
00 00
46 00
// row 1
1e 00
14 14
08 00
00 00
00 00
32 32
0d 0d
00 00
// row 2
00 00
00 00
0f 0f
00 00
14 14
0c 00
1e 1e
5a 00
// row 3
19 00
64 64
28 28
00 00
30 00
00 00
31 31
c8 00
// row 4
00 00
00 00
00 00
00 00
00 00
00 00
00 00
ff 00

/* canny_hysteresis.f */
+incdir+source
source/hysteresis_pkg.sv
source/pixel_fifo.sv
source/hysteresis_control.sv
source/raster_counter.sv
source/window_buffer.sv
source/edge_classifier.sv
source/edge_map_ram.sv
source/hysteresis_top.sv
testbench/clock_gen.sv
testbench/hysteresis_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the hysteresis testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f canny_hysteresis.f --top-module hysteresis_tb -o hysteresis_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/hysteresis_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "All checks passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
